//--- list.f
source/map_pkg.sv
source/vga_scan.sv
source/terrain.sv
source/map_level.sv
source/player_contact.sv
source/game_fsm.sv
source/game_top.sv
test/tb_checker.sv
test/tb_game.sv

//--- test/tb_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game;
    import map_pkg::*;

    localparam int H_ACTIVE  = 640;
    localparam int H_TOTAL   = 800;
    localparam int V_ACTIVE  = 480;
    localparam int V_TOTAL   = 525;
    localparam int N_RANDOM  = 40;
    localparam int ACK_LIMIT = 20;

    typedef struct packed {
        logic [159:0] name;
        player_pos_t  p1;
        player_pos_t  p2;
        logic         start;
        logic         rules;        // checker derives the contact bits itself.
        contact_t     exp;
        logic [2:0]   ctrl;         // en, clear, fail.
    } row_t;

    logic        clk;
    logic        rst;
    logic        start;
    player_pos_t p1_pos;
    player_pos_t p2_pos;
    coord_t      vga_h;
    coord_t      vga_v;
    addr_t       addr;
    logic        p1_land;
    logic        p2_land;
    logic        p1_hazard;
    logic        p2_hazard;
    logic        en;
    logic        clear;
    logic        fail;
    logic        req;
    logic        ack;
    logic        frame_done;
    int          errors;
    int          checks;
    row_t        cur;
    row_t        rows [$];
    logic [15:0] lfsr;
    logic        timed_out;

    always #5 clk = ~clk;

    game_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .p1_pos    (p1_pos),
        .p2_pos    (p2_pos),
        .vga_h     (vga_h),
        .vga_v     (vga_v),
        .addr      (addr),
        .p1_land   (p1_land),
        .p2_land   (p2_land),
        .p1_hazard (p1_hazard),
        .p2_hazard (p2_hazard),
        .en        (en),
        .clear     (clear),
        .fail      (fail)
    );

    tb_checker #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) chk0 (
        .clk         (clk),
        .rst         (rst),
        .p1_pos      (p1_pos),
        .p2_pos      (p2_pos),
        .vga_h       (vga_h),
        .vga_v       (vga_v),
        .addr        (addr),
        .p1_land     (p1_land),
        .p2_land     (p2_land),
        .p1_hazard   (p1_hazard),
        .p2_hazard   (p2_hazard),
        .en          (en),
        .clear       (clear),
        .fail        (fail),
        .req         (req),
        .use_rules   (cur.rules),
        .name        (cur.name),
        .exp_contact (cur.exp),
        .exp_ctrl    (cur.ctrl),
        .ack         (ack),
        .frame_done  (frame_done),
        .errors      (errors),
        .checks      (checks)
    );

    // galois form, taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // lh is land1, land2, hazard1, hazard2.
    task automatic add_row(input logic [159:0] n, input int x1, input int y1, input int x2,
                           input int y2, input logic st, input logic [3:0] lh,
                           input logic [2:0] c);
        row_t r;
        r.name  = n;
        r.p1.x  = coord_t'(x1);
        r.p1.y  = coord_t'(y1);
        r.p2.x  = coord_t'(x2);
        r.p2.y  = coord_t'(y2);
        r.start = st;
        r.rules = 1'b0;
        r.exp   = {lh, 1'b0};       // at_doors has no port.
        r.ctrl  = c;
        rows.push_back(r);
    endtask

    task automatic add_random_row();
        int x1;
        int y1;
        int x2;
        int y2;
        draw_bits(9, x1);
        draw_bits(8, y1);
        draw_bits(9, x2);
        draw_bits(8, y2);
        add_row("random", x1 % 320, y1 % 240, x2 % 320, y2 % 240, 1'b1, 4'b0000, 3'b000);
        rows[rows.size() - 1].rules = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table.
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_table();
        add_row("reset_idle",       20, 214, 231, 166, 1'b0, 4'b0000, 3'b000);
        add_row("start_play",       20, 214,  60, 100, 1'b1, 4'b1000, 3'b100);
        add_row("land_wall1",      100, 166,  60, 100, 1'b0, 4'b1000, 3'b100);
        add_row("land_wall1_edge",  60, 100, 231, 166, 1'b0, 4'b0100, 3'b100);
        add_row("one_row_high",    100, 165,  60, 100, 1'b0, 4'b0000, 3'b100);
        add_row("off_span",        240, 166,  20, 214, 1'b0, 4'b0100, 3'b100);
        add_row("p2_in_blue",       60, 100, 220, 220, 1'b0, 4'b0000, 3'b100);
        add_row("p1_in_red",       160, 220,  60, 100, 1'b0, 4'b0000, 3'b100);
        add_row("p1_in_blue",      220, 220,  60, 100, 1'b0, 4'b0010, 3'b001);
        add_row("fail_holds",       20, 214, 231, 166, 1'b0, 4'b0000, 3'b001);
        add_row("restart_fail",     50, 100,  60, 100, 1'b1, 4'b0000, 3'b100);
        add_row("p2_in_red",        60, 100, 160, 220, 1'b0, 4'b0001, 3'b001);
        add_row("restart_a",        50, 100,  60, 100, 1'b1, 4'b0000, 3'b100);
        add_row("swapped_doors",   285,  25, 255,  25, 1'b0, 4'b0000, 3'b100);
        add_row("doors_clear",     255,  25, 285,  25, 1'b0, 4'b0000, 3'b010);
        add_row("clear_holds",     100, 166,  20, 214, 1'b0, 4'b0000, 3'b010);
        add_row("restart_clear",    50, 100,  60, 100, 1'b1, 4'b0000, 3'b100);
        add_row("hazard_near_door", 255,  25, 160, 220, 1'b0, 4'b0001, 3'b001);
        add_row("restart_b",        50, 100,  60, 100, 1'b1, 4'b0000, 3'b100);
        add_row("door_edge",       263,  32, 293,  32, 1'b0, 4'b1100, 3'b010);
        add_row("restart_c",        50, 100,  60, 100, 1'b1, 4'b0000, 3'b100);
        add_row("door_miss",       264,  32, 293,  32, 1'b0, 4'b1100, 3'b100);
        for (int k = 0; k < N_RANDOM; k++) begin
            add_random_row();
        end
    endtask

    task automatic wait_ack(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < ACK_LIMIT && !ok; n++) begin
            @(posedge clk);
            ok = ack;
        end
    endtask

    initial begin
        logic ok;
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        p1_pos    = '0;
        p2_pos    = '0;
        req       = 1'b0;
        cur       = '0;
        lfsr      = 16'd72;
        timed_out = 1'b0;
        build_table();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        foreach (rows[i]) begin
            @(negedge clk);
            cur    = rows[i];
            p1_pos = cur.p1;
            p2_pos = cur.p2;
            start  = cur.start;
            req    = 1'b1;
            @(negedge clk);
            start = 1'b0;                   // start is a one clock pulse.
            req   = 1'b0;
            wait_ack(ok);
            if (!ok) begin
                $display("timeout: checker gave no response for row %0d", i);
                timed_out = 1'b1;
                break;
            end
        end

        // address map needs at least one full frame.
        if (!timed_out) begin
            ok = 1'b0;
            for (int n = 0; n < H_TOTAL * V_TOTAL + 100 && !ok; n++) begin
                @(posedge clk);
                ok = frame_done;
            end
            if (!ok) begin
                $display("timeout: the scan never finished a frame");
                timed_out = 1'b1;
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (!timed_out && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire map_pkg::player_pos_t p1_pos,
    input  wire map_pkg::player_pos_t p2_pos,
    input  wire map_pkg::coord_t      vga_h,
    input  wire map_pkg::coord_t      vga_v,
    input  wire map_pkg::addr_t       addr,
    input  wire                       p1_land,
    input  wire                       p2_land,
    input  wire                       p1_hazard,
    input  wire                       p2_hazard,
    input  wire                       en,
    input  wire                       clear,
    input  wire                       fail,
    input  wire                       req,
    input  wire                       use_rules,
    input  wire [159:0]               name,
    input  wire map_pkg::contact_t    exp_contact,
    input  wire [2:0]                 exp_ctrl,     // en, clear, fail.
    output logic                      ack,
    output logic                      frame_done,
    output int                        errors,
    output int                        checks
);
    import map_pkg::*;

    int   model_h;
    int   model_v;
    logic live;

    task automatic compare(input logic [159:0] test, input string what,
                           input logic [31:0] want, input logic [31:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0s: %0s expected %0d, actual %0d", test, what, want, got);
        end
    endtask

    // [a, a+alen) and [b, b+blen) share a pixel.
    function automatic bit spans_meet(int a, int alen, int b, int blen);
        return (a < b + blen) && (b < a + alen);
    endfunction

    function automatic bit span_within(int a, int alen, int b, int blen);
        return (a >= b) && (a + alen <= b + blen);
    endfunction

    function automatic bit box_meets(player_pos_t p, map_rect_t r);
        return spans_meet(p.x, PLAYER_W, r.pivot_h, r.width) &&
               spans_meet(p.y, PLAYER_H, r.pivot_v, r.height);
    endfunction

    function automatic bit box_within(player_pos_t p, map_rect_t r);
        return span_within(p.x, PLAYER_W, r.pivot_h, r.width) &&
               span_within(p.y, PLAYER_H, r.pivot_v, r.height);
    endfunction

    function automatic bit stands_on(player_pos_t p, map_rect_t r);
        return (int'(p.y) + int'(PLAYER_H) == int'(r.pivot_v)) &&
               spans_meet(p.x, PLAYER_W, r.pivot_h, r.width);
    endfunction

    // player 1 is red, player 2 is blue.
    function automatic contact_t rule_contact(player_pos_t a, player_pos_t b);
        contact_t  c;
        bit        home1;
        bit        home2;
        map_rect_t r;
        c     = '0;
        home1 = 1'b0;
        home2 = 1'b0;
        for (int i = 0; i < N_RECTS; i++) begin
            r = MAP_RECTS[i];
            if (r.kind == solid) begin
                c.land1 = c.land1 | stands_on(a, r);
                c.land2 = c.land2 | stands_on(b, r);
            end else if (r.kind == blue_river) begin
                c.hazard1 = c.hazard1 | box_meets(a, r);
            end else if (r.kind == red_river) begin
                c.hazard2 = c.hazard2 | box_meets(b, r);
            end else if (r.kind == red_door) begin
                home1 = home1 | box_within(a, r);
            end else if (r.kind == blue_door) begin
                home2 = home2 | box_within(b, r);
            end
        end
        c.at_doors = home1 & home2;
        return c;
    endfunction

    // first rectangle in table order wins.
    function automatic int ref_addr(int sh, int sv);
        int        h;
        int        v;
        map_rect_t r;
        h = sh / 2;
        v = sv / 2;
        if (sh >= H_ACTIVE || sv >= V_ACTIVE) begin
            return BG_ADDR;
        end
        for (int i = 0; i < N_RECTS; i++) begin
            r = MAP_RECTS[i];
            if (h >= r.pivot_h && h < r.pivot_h + r.width &&
                v >= r.pivot_v && v < r.pivot_v + r.height) begin
                return r.mem_h + (h - r.pivot_h) + (r.mem_v + v - r.pivot_v) * MEM_ROW;
            end
        end
        return BG_ADDR;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // scan model and address map.
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            model_h    <= 0;
            model_v    <= 0;
            live       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            live <= 1'b1;
            if (model_h == H_TOTAL - 1) begin
                model_h <= 0;
                if (model_v == V_TOTAL - 1) begin
                    model_v    <= 0;
                    frame_done <= 1'b1;     // whole frame seen.
                end else begin
                    model_v <= model_v + 1;
                end
            end else begin
                model_h <= model_h + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (live) begin
            compare("scan", "vga_h", model_h, vga_h);
            compare("scan", "vga_v", model_v, vga_v);
            compare("addr_map", "addr", ref_addr(model_h, model_v), addr);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // per row checks.
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        contact_t   want;
        logic [2:0] ctrl;
        errors = 0;
        checks = 0;
        ack    = 1'b0;
        forever begin
            @(posedge clk);
            if (req) begin
                want = use_rules ? rule_contact(p1_pos, p2_pos) : exp_contact;
                ctrl = exp_ctrl;
                if (use_rules) begin
                    ctrl[0] = want.hazard1 | want.hazard2;     // hazard beats the doors.
                    ctrl[1] = !ctrl[0] & want.at_doors;
                    ctrl[2] = !ctrl[0] & !ctrl[1];
                end
                @(negedge clk);                                 // contact after 1 clock.
                compare(name, "p1_land", want.land1, p1_land);
                compare(name, "p2_land", want.land2, p2_land);
                compare(name, "p1_hazard", want.hazard1, p1_hazard);
                compare(name, "p2_hazard", want.hazard2, p2_hazard);
                @(posedge clk);
                @(negedge clk);                                 // state after 2 clocks.
                compare(name, "en", ctrl[2], en);
                compare(name, "clear", ctrl[1], clear);
                compare(name, "fail", ctrl[0], fail);
                ack = 1'b1;
                @(negedge clk);
                ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/game_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire map_pkg::player_pos_t p1_pos,
    input  wire map_pkg::player_pos_t p2_pos,
    output map_pkg::coord_t           vga_h,
    output map_pkg::coord_t           vga_v,
    output map_pkg::addr_t            addr,
    output logic                      p1_land,
    output logic                      p2_land,
    output logic                      p1_hazard,
    output logic                      p2_hazard,
    output logic                      en,
    output logic                      clear,
    output logic                      fail
);
    import map_pkg::*;

    logic     active;
    contact_t contact;

    vga_scan #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_scan (
        .clk    (clk),
        .rst    (rst),
        .vga_h  (vga_h),
        .vga_v  (vga_v),
        .active (active)
    );

    map_level u_map (
        .vga_h  (vga_h),
        .vga_v  (vga_v),
        .active (active),
        .addr   (addr)
    );

    player_contact u_contact (
        .clk     (clk),
        .rst     (rst),
        .p1_pos  (p1_pos),
        .p2_pos  (p2_pos),
        .contact (contact)
    );

    game_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .contact (contact),
        .en      (en),
        .clear   (clear),
        .fail    (fail)
    );

    // contact is only reported while the level is running.
    assign p1_land   = en & contact.land1;
    assign p2_land   = en & contact.land2;
    assign p1_hazard = en & contact.hazard1;
    assign p2_hazard = en & contact.hazard2;

endmodule

`default_nettype wire

//--- source/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire map_pkg::contact_t contact,
    output logic                   en,
    output logic                   clear,
    output logic                   fail
);
    import map_pkg::*;

    game_state_t state;
    game_state_t state_next;

    ////////////////////////////////////////////////////////////////////////////
    // next state.
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_play;
                end
            end
            st_play: begin
                // a hazard beats reaching the doors.
                if (contact.hazard1 || contact.hazard2) begin
                    state_next = st_fail;
                end else if (contact.at_doors) begin
                    state_next = st_clear;
                end
            end
            st_clear, st_fail: begin
                if (start) begin
                    state_next = st_play;   // restart.
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    assign en    = (state == st_play);
    assign clear = (state == st_clear);
    assign fail  = (state == st_fail);

endmodule

`default_nettype wire

//--- source/player_contact.sv
`timescale 1ns/1ps
`default_nettype none

module player_contact (
    input  wire                      clk,
    input  wire                      rst,
    input  wire map_pkg::player_pos_t p1_pos,
    input  wire map_pkg::player_pos_t p2_pos,
    output map_pkg::contact_t        contact
);
    import map_pkg::*;

    contact_t contact_next;
    logic     in_red;
    logic     in_blue;

    // true when [pos, pos+size) and [piv, piv+len) share a pixel.
    function automatic logic span_overlap(coord_t pos, coord_t size, coord_t piv, coord_t len);
        return ({1'b0, pos} < {1'b0, piv} + len) && ({1'b0, pos} + size > {1'b0, piv});
    endfunction

    function automatic logic span_inside(coord_t pos, coord_t size, coord_t piv, coord_t len);
        return (pos >= piv) && ({1'b0, pos} + size <= {1'b0, piv} + len);
    endfunction

    function automatic logic box_overlaps(player_pos_t p, map_rect_t r);
        return span_overlap(p.x, PLAYER_W, r.pivot_h, r.width) &&
               span_overlap(p.y, PLAYER_H, r.pivot_v, r.height);
    endfunction

    function automatic logic box_inside(player_pos_t p, map_rect_t r);
        return span_inside(p.x, PLAYER_W, r.pivot_h, r.width) &&
               span_inside(p.y, PLAYER_H, r.pivot_v, r.height);
    endfunction

    // feet exactly on the top row of the block.
    function automatic logic lands_on(player_pos_t p, map_rect_t r);
        return ({1'b0, p.y} + PLAYER_H == {1'b0, r.pivot_v}) &&
               span_overlap(p.x, PLAYER_W, r.pivot_h, r.width);
    endfunction

    always_comb begin
        contact_next = '0;
        in_red       = 1'b0;
        in_blue      = 1'b0;
        for (int i = 0; i < N_RECTS; i++) begin
            case (MAP_RECTS[i].kind)
                solid: begin
                    contact_next.land1 |= lands_on(p1_pos, MAP_RECTS[i]);
                    contact_next.land2 |= lands_on(p2_pos, MAP_RECTS[i]);
                end
                red_river:  contact_next.hazard2 |= box_overlaps(p2_pos, MAP_RECTS[i]);
                blue_river: contact_next.hazard1 |= box_overlaps(p1_pos, MAP_RECTS[i]);
                red_door:   in_red  |= box_inside(p1_pos, MAP_RECTS[i]);
                blue_door:  in_blue |= box_inside(p2_pos, MAP_RECTS[i]);
                default: ;
            endcase
        end
        contact_next.at_doors = in_red & in_blue;   // both must be home.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            contact <= '0;
        end else begin
            contact <= contact_next;
        end
    end

endmodule

`default_nettype wire

//--- source/map_level.sv
`timescale 1ns/1ps
`default_nettype none

module map_level (
    input  wire map_pkg::coord_t vga_h,
    input  wire map_pkg::coord_t vga_v,
    input  wire                  active,
    output map_pkg::addr_t       addr
);
    import map_pkg::*;

    coord_t h;
    coord_t v;
    logic   hit [N_RECTS];
    addr_t  rect_addr [N_RECTS];

    // sprite sheet is stored at half resolution.
    assign h = vga_h >> 1;
    assign v = vga_v >> 1;

    ////////////////////////////////////////////////////////////////////////////
    // one hit test per table entry.
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < N_RECTS; i++) begin : g_rect
        terrain u_terrain (
            .rect (MAP_RECTS[i]),
            .h    (h),
            .v    (v),
            .hit  (hit[i]),
            .addr (rect_addr[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // priority select.
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        addr = BG_ADDR;                     // nothing drawn here.
        if (active) begin
            // walk backwards so the lowest index is applied last.
            for (int i = N_RECTS - 1; i >= 0; i--) begin
                if (hit[i]) begin
                    addr = rect_addr[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/terrain.sv
`timescale 1ns/1ps
`default_nettype none

module terrain (
    input  wire map_pkg::map_rect_t rect,
    input  wire map_pkg::coord_t    h,
    input  wire map_pkg::coord_t    v,
    output logic                    hit,
    output map_pkg::addr_t          addr
);
    import map_pkg::*;

    logic [10:0] end_h;         // one past the right column.
    logic [10:0] end_v;
    coord_t      off_h;
    coord_t      off_v;
    addr_t       mem_row;

    assign end_h = {1'b0, rect.pivot_h} + {1'b0, rect.width};
    assign end_v = {1'b0, rect.pivot_v} + {1'b0, rect.height};

    assign hit = (h >= rect.pivot_h) && ({1'b0, h} < end_h) &&
                 (v >= rect.pivot_v) && ({1'b0, v} < end_v);

    // offset inside the rectangle, mapped onto the sprite sheet.
    assign off_h   = h - rect.pivot_h;
    assign off_v   = v - rect.pivot_v;
    assign mem_row = addr_t'(rect.mem_v) + addr_t'(off_v);
    assign addr    = addr_t'(rect.mem_h) + addr_t'(off_h) + mem_row * MEM_ROW;

endmodule

`default_nettype wire

//--- source/vga_scan.sv
`timescale 1ns/1ps
`default_nettype none

module vga_scan #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  wire               clk,
    input  wire               rst,
    output map_pkg::coord_t   vga_h,
    output map_pkg::coord_t   vga_v,
    output logic              active
);
    import map_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = (vga_h == coord_t'(H_TOTAL - 1));
    assign v_last = (vga_v == coord_t'(V_TOTAL - 1));

    ////////////////////////////////////////////////////////////////////////////
    // pixel and line counters.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_h <= '0;
            vga_v <= '0;
        end else if (h_last) begin
            vga_h <= '0;
            if (v_last) begin
                vga_v <= '0;        // new frame.
            end else begin
                vga_v <= vga_v + 1'b1;
            end
        end else begin
            vga_h <= vga_h + 1'b1;
        end
    end

    // visible region sits at the start of each line and frame.
    assign active = (vga_h < coord_t'(H_ACTIVE)) && (vga_v < coord_t'(V_ACTIVE));

endmodule

`default_nettype wire

//--- source/map_pkg.sv
`default_nettype none

package map_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [16:0] addr_t;

    typedef enum logic [2:0] {
        solid,
        red_river,
        blue_river,
        red_door,
        blue_door
    } rect_kind_t;

    // one rectangle of terrain, screen position plus where its art sits in memory.
    typedef struct packed {
        coord_t     pivot_h;
        coord_t     pivot_v;
        coord_t     width;
        coord_t     height;
        coord_t     mem_h;
        coord_t     mem_v;
        rect_kind_t kind;
    } map_rect_t;

    typedef struct packed {
        coord_t x;              // top-left corner, half resolution.
        coord_t y;
    } player_pos_t;

    typedef struct packed {
        logic land1;
        logic land2;
        logic hazard1;
        logic hazard2;
        logic at_doors;
    } contact_t;

    typedef enum logic [1:0] {
        st_idle,
        st_play,
        st_clear,
        st_fail
    } game_state_t;

    localparam coord_t PLAYER_W = 10'd10;
    localparam coord_t PLAYER_H = 10'd16;
    localparam addr_t  MEM_ROW  = 17'd320;
    localparam addr_t  BG_ADDR  = 17'd12900;

    ////////////////////////////////////////////////////////////////////////////
    // level layout, earlier entries are drawn on top.
    ////////////////////////////////////////////////////////////////////////////
    localparam int N_RECTS = 14;

    localparam map_rect_t MAP_RECTS [N_RECTS] = '{
        '{10'd0,   10'd0,   10'd320, 10'd10,  10'd0,   10'd220, solid},      // ceiling.
        '{10'd150, 10'd230, 10'd40,  10'd6,   10'd0,   10'd65,  red_river},
        '{10'd210, 10'd230, 10'd40,  10'd6,   10'd55,  10'd70,  blue_river},
        '{10'd0,   10'd230, 10'd320, 10'd10,  10'd0,   10'd220, solid},      // floor.
        '{10'd0,   10'd10,  10'd10,  10'd220, 10'd305, 10'd10,  solid},      // left edge.
        '{10'd310, 10'd10,  10'd10,  10'd220, 10'd305, 10'd10,  solid},      // right edge.
        '{10'd10,  10'd182, 10'd230, 10'd8,   10'd50,  10'd215, solid},      // wall 1.
        '{10'd90,  10'd139, 10'd220, 10'd8,   10'd0,   10'd220, solid},
        '{10'd85,  10'd96,  10'd185, 10'd8,   10'd0,   10'd220, solid},
        '{10'd160, 10'd89,  10'd50,  10'd8,   10'd0,   10'd220, solid},
        '{10'd110, 10'd48,  10'd200, 10'd8,   10'd0,   10'd220, solid},
        '{10'd275, 10'd210, 10'd35,  10'd20,  10'd0,   10'd218, solid},      // wall 6.
        '{10'd250, 10'd19,  10'd23,  10'd29,  10'd0,   10'd89,  red_door},
        '{10'd280, 10'd19,  10'd23,  10'd29,  10'd32,  10'd89,  blue_door}
    };

endpackage

`default_nettype wire
